// ==== aspect_ratio.sv ====
/* Aspect ratio for the scaler. Core values follow the standard and crop one cycle late;
   crop 3 keeps the previous values. */
`timescale 1ns/1ps

module aspect_ratio (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        pal,
	input  logic        fixed_blanks_off,
	input  logic [1:0]  crop,
	input  logic [1:0]  ar_mode,
	output logic [12:0] video_arx,
	output logic [12:0] video_ary
);
	import n64_glue_pkg::*;

	ar_value_t core_x;
	ar_value_t core_y;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			core_x <= AR_DEFAULT_X;
			core_y <= AR_DEFAULT_Y;
		end else if (fixed_blanks_off) begin
			// Full frame with blanks, plain 4:3
			core_x <= AR_DEFAULT_X;
			core_y <= AR_DEFAULT_Y;
		end else if (crop != 2'd3) begin
			core_x <= AR_CROP_X[pal][crop];
			core_y <= AR_CROP_Y[pal][crop];
		end
	end

	// ============================================================
	// Output select
	// ============================================================
	// Mode 0 is the core ratio, others pass the scaler preset index
	always_comb begin
		if (ar_mode == 2'd0) begin
			video_arx = {1'b0, core_x};
			video_ary = {1'b0, core_y};
		end else begin
			video_arx = {11'd0, ar_mode - 2'd1};
			video_ary = 13'd0;
		end
	end

endmodule

// ==== build.f ====
n64_glue_pkg.sv
ioctl_if.sv
dl_router.sv
pifrom_packer.sv
gbcart_writer.sv
aspect_ratio.sv
snac_port_mux.sv
n64_glue_top.sv
tb_n64_glue.sv

// ==== dl_router.sv ====
/* Decodes the download target and keeps per-target levels, all one cycle behind the host.
   The ROM copy starts only when an N64 cartridge download ends. */
`timescale 1ns/1ps

module dl_router (
	input  logic                      clk_1x,
	input  logic                      rst_n,
	ioctl_if.router                   bus,
	output logic                      pif_sel,
	output logic                      gb_sel,
	output logic                      romcopy_start,
	output n64_glue_pkg::ioctl_addr_t romcopy_size,
	output logic                      cart_loaded,
	output logic                      led_user
);
	import n64_glue_pkg::*;

	logic [5:0] target;
	logic       n64_sel;
	logic       download_d;
	logic       n64_done;

	assign target = bus.index[5:0];

	// Falling edge of download while the N64 target is selected
	assign n64_done = !bus.download && download_d && (target == IDX_CART_N64);

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			pif_sel       <= 1'b0;
			gb_sel        <= 1'b0;
			n64_sel       <= 1'b0;
			download_d    <= 1'b0;
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
		end else begin
			pif_sel       <= bus.download && (target == IDX_PIFROM);
			n64_sel       <= bus.download && (target == IDX_CART_N64);
			gb_sel        <= bus.download && (target == IDX_CART_GB);
			download_d    <= bus.download;
			romcopy_start <= n64_done;
			// Sticky once any N64 image was seen
			if (n64_sel)
				cart_loaded <= 1'b1;
		end
	end

	// Final byte count of the image
	always_ff @(posedge clk_1x) begin
		if (n64_done)
			romcopy_size <= bus.addr;
	end

	assign led_user = n64_sel | gb_sel;

	a_romcopy_single : assert property (@(posedge clk_1x) disable iff (!rst_n)
		romcopy_start |=> !romcopy_start);

endmodule

// ==== gbcart_writer.sv ====
/* Writes the GB cartridge image to RAM one 32-bit word at a time. The host is held
   in wait from each word request until the RAM acknowledges it. */
`timescale 1ns/1ps

module gbcart_writer (
	input  logic                      clk_1x,
	input  logic                      rst_n,
	ioctl_if.sink                     bus,
	input  logic                      gb_sel,
	input  logic                      ram_ready,
	output n64_glue_pkg::ioctl_addr_t ram_wraddr,
	output n64_glue_pkg::ram_word_t   ram_wrdata,
	output logic                      ram_wr
);
	import n64_glue_pkg::*;

	logic first_half;
	logic second_half;

	assign first_half  = gb_sel && bus.wr && !bus.addr[1];
	assign second_half = gb_sel && bus.wr && bus.addr[1];

	// ============================================================
	// Request and host wait
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			ram_wr      <= 1'b0;
			bus.wr_wait <= 1'b0;
		end else begin
			ram_wr <= second_half;
			if (!gb_sel) begin
				bus.wr_wait <= 1'b0;
			end else begin
				if (second_half)
					bus.wr_wait <= 1'b1;
				// Late acknowledge just keeps the host waiting
				if (ram_ready)
					bus.wr_wait <= 1'b0;
			end
		end
	end

	// ============================================================
	// Word assembly, low half first
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (first_half) begin
			ram_wrdata[15:0] <= bus.dout;
			ram_wraddr       <= bus.addr + CARTGB_START;
		end else if (second_half) begin
			ram_wrdata[31:16] <= bus.dout;
		end
	end

	a_no_wr_in_wait : assert property (@(posedge clk_1x) disable iff (!rst_n)
		bus.wr_wait |-> !bus.wr);

endmodule

// ==== ioctl_if.sv ====
/* Host download bus. wr is a one-cycle strobe per halfword and must stay low
   while wr_wait is high. */
`timescale 1ns/1ps

interface ioctl_if;
	import n64_glue_pkg::*;

	logic        download;
	dl_index_t   index;
	ioctl_addr_t addr;
	ioctl_word_t dout;
	logic        wr;
	// Host hold request, raised by the RAM writer
	logic        wr_wait;

	modport host   (output download, index, addr, dout, wr, input wr_wait);
	modport router (input download, index, addr);
	modport sink   (input addr, dout, wr, output wr_wait);
	// Sink that never stalls the host
	modport sink_ro (input addr, dout, wr);

endinterface

// ==== n64_glue_pkg.sv ====
/* Shared widths, download target codes and lookup tables for the console glue logic.
   Aspect table rows are indexed by video standard (0 NTSC, 1 PAL) and by crop 0 to 2. */
package n64_glue_pkg;

	// ============================================================
	// Vector types
	// ============================================================
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [15:0] ioctl_word_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [31:0] ram_word_t;
	typedef logic [9:0]  pif_addr_t;
	typedef logic [11:0] ar_value_t;
	typedef logic [6:0]  user_port_t;
	typedef logic [1:0]  pad_index_t;

	// ============================================================
	// Download targets, low 6 bits of the index
	// ============================================================
	localparam logic [5:0] IDX_PIFROM   = 6'd0;
	localparam logic [5:0] IDX_CART_N64 = 6'd1;
	localparam logic [5:0] IDX_CART_GB  = 6'd2;

	// Byte offset of the GB cartridge image in RAM
	localparam ioctl_addr_t CARTGB_START = 27'd8388608;

	// ============================================================
	// Aspect ratio
	// ============================================================
	localparam ar_value_t AR_DEFAULT_X = 12'd4;
	localparam ar_value_t AR_DEFAULT_Y = 12'd3;

	// [standard][crop]
	localparam ar_value_t [0:1][0:2] AR_CROP_X = '{
		'{12'd512, 12'd1280, 12'd2560},
		'{12'd512, 12'd1024, 12'd2048}
	};
	localparam ar_value_t [0:1][0:2] AR_CROP_Y = '{
		'{12'd381, 12'd889, 12'd1714},
		'{12'd387, 12'd731, 12'd1419}
	};

	// User port pin per serial pad
	localparam logic [2:0] SNAC_PIN_PAD0 = 3'd1;
	localparam logic [2:0] SNAC_PIN_PAD1 = 3'd0;
	localparam logic [2:0] SNAC_PIN_PAD2 = 3'd5;
	localparam logic [2:0] SNAC_PIN_PAD3 = 3'd4;

endpackage

// ==== n64_glue_top.sv ====
/* System glue around the console core. One clock domain; the host must keep wr low
   while ioctl_wait is high. */
`timescale 1ns/1ps

module n64_glue_top (
	input  logic                      clk_1x,
	input  logic                      rst_n,
	// Host download
	input  logic                      ioctl_download,
	input  n64_glue_pkg::dl_index_t   ioctl_index,
	input  n64_glue_pkg::ioctl_addr_t ioctl_addr,
	input  n64_glue_pkg::ioctl_word_t ioctl_dout,
	input  logic                      ioctl_wr,
	output logic                      ioctl_wait,
	// Boot ROM
	output n64_glue_pkg::pif_addr_t   pifrom_wraddress,
	output n64_glue_pkg::ram_word_t   pifrom_wrdata,
	output logic                      pifrom_wren,
	// RAM write channel
	output n64_glue_pkg::ioctl_addr_t ram_wraddr,
	output n64_glue_pkg::ram_word_t   ram_wrdata,
	output logic                      ram_wr,
	input  logic                      ram_ready,
	// Cartridge status
	output logic                      romcopy_start,
	output n64_glue_pkg::ioctl_addr_t romcopy_size,
	output logic                      cart_loaded,
	output logic                      led_user,
	// Video
	input  logic                      pal,
	input  logic                      fixed_blanks_off,
	input  logic [1:0]                crop,
	input  logic [1:0]                ar_mode,
	output logic [12:0]               video_arx,
	output logic [12:0]               video_ary,
	// Serial pads
	input  logic                      snac,
	input  n64_glue_pkg::pad_index_t  pad_index,
	input  logic                      snac_data_out,
	output logic                      snac_data_in,
	input  n64_glue_pkg::user_port_t  user_in,
	output n64_glue_pkg::user_port_t  user_out
);

	logic pif_sel;
	logic gb_sel;

	ioctl_if ioctl_bus ();

	assign ioctl_bus.download = ioctl_download;
	assign ioctl_bus.index    = ioctl_index;
	assign ioctl_bus.addr     = ioctl_addr;
	assign ioctl_bus.dout     = ioctl_dout;
	assign ioctl_bus.wr       = ioctl_wr;
	assign ioctl_wait         = ioctl_bus.wr_wait;

	dl_router router_i (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.bus           (ioctl_bus.router),
		.pif_sel       (pif_sel),
		.gb_sel        (gb_sel),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cart_loaded   (cart_loaded),
		.led_user      (led_user)
	);

	// Index bit 6 selects the boot ROM bank
	pifrom_packer pifrom_i (
		.clk_1x           (clk_1x),
		.rst_n            (rst_n),
		.bus              (ioctl_bus.sink_ro),
		.pif_sel          (pif_sel),
		.index_bank       (ioctl_index[6]),
		.pifrom_wraddress (pifrom_wraddress),
		.pifrom_wrdata    (pifrom_wrdata),
		.pifrom_wren      (pifrom_wren)
	);

	gbcart_writer gbcart_i (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.bus        (ioctl_bus.sink),
		.gb_sel     (gb_sel),
		.ram_ready  (ram_ready),
		.ram_wraddr (ram_wraddr),
		.ram_wrdata (ram_wrdata),
		.ram_wr     (ram_wr)
	);

	aspect_ratio aspect_i (
		.clk_1x           (clk_1x),
		.rst_n            (rst_n),
		.pal              (pal),
		.fixed_blanks_off (fixed_blanks_off),
		.crop             (crop),
		.ar_mode          (ar_mode),
		.video_arx        (video_arx),
		.video_ary        (video_ary)
	);

	snac_port_mux snac_i (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.snac          (snac),
		.pad_index     (pad_index),
		.snac_data_out (snac_data_out),
		.user_in       (user_in),
		.user_out      (user_out),
		.snac_data_in  (snac_data_in)
	);

endmodule

// ==== pifrom_packer.sv ====
/* Packs host halfword pairs into byte-swapped boot-ROM words. The first halfword of a
   word must arrive with addr bit 1 clear, the second with it set. */
`timescale 1ns/1ps

module pifrom_packer (
	input  logic                    clk_1x,
	input  logic                    rst_n,
	ioctl_if.sink_ro                bus,
	input  logic                    pif_sel,
	input  logic                    index_bank,
	output n64_glue_pkg::pif_addr_t pifrom_wraddress,
	output n64_glue_pkg::ram_word_t pifrom_wrdata,
	output logic                    pifrom_wren
);
	import n64_glue_pkg::*;

	ioctl_word_t swapped;
	logic        accept;

	assign swapped = {bus.dout[7:0], bus.dout[15:8]};
	assign accept  = pif_sel && bus.wr;

	always_ff @(posedge clk_1x) begin
		if (!rst_n)
			pifrom_wren <= 1'b0;
		else
			pifrom_wren <= accept && bus.addr[1];
	end

	// Upper half and address on the first halfword, lower half on the second
	always_ff @(posedge clk_1x) begin
		if (accept) begin
			if (!bus.addr[1]) begin
				pifrom_wrdata[31:16] <= swapped;
				pifrom_wraddress     <= {index_bank, bus.addr[10:2]};
			end else begin
				pifrom_wrdata[15:0] <= swapped;
			end
		end
	end

	a_wren_in_download : assert property (@(posedge clk_1x) disable iff (!rst_n)
		pifrom_wren |-> $past(pif_sel));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f build.f --top-module tb_n64_glue -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/Vtb_n64_glue > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error status"
	exit 1
fi

cat "$LOG"
if grep -qx "TEST PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== snac_port_mux.sv ====
/* Routes the serial pad data line to the user-port pin of the selected pad.
   Pins are open drain, so idle and unused pins are driven high. */
`timescale 1ns/1ps

module snac_port_mux (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	input  logic                     snac,
	input  n64_glue_pkg::pad_index_t pad_index,
	input  logic                     snac_data_out,
	input  n64_glue_pkg::user_port_t user_in,
	output n64_glue_pkg::user_port_t user_out,
	output logic                     snac_data_in
);
	import n64_glue_pkg::*;

	logic [2:0] pad_pin;

	always_comb begin
		case (pad_index)
			2'd0:    pad_pin = SNAC_PIN_PAD0;
			2'd1:    pad_pin = SNAC_PIN_PAD1;
			2'd2:    pad_pin = SNAC_PIN_PAD2;
			default: pad_pin = SNAC_PIN_PAD3;
		endcase
	end

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			user_out     <= '1;
			snac_data_in <= 1'b0;
		end else if (snac) begin
			// Other pad pins keep what they had
			user_out[pad_pin] <= snac_data_out;
			snac_data_in      <= user_in[pad_pin];
			user_out[2]       <= 1'b1;
			user_out[3]       <= 1'b1;
			user_out[6]       <= 1'b1;
		end else begin
			user_out <= '1;
		end
	end

endmodule

// ==== tb_n64_glue.sv ====
/* Testbench for the console glue top level. Checks run as concurrent assertions against a
   cycle model of the host bus; the RAM acknowledges after 0 to 5 cycles. */
`timescale 1ns/1ps

module tb_n64_glue;
	import n64_glue_pkg::*;

	// Worst-case sequence length is well under half of this
	localparam int TIMEOUT_CYCLES = 4000;

	logic        clk_1x = 1'b0;
	logic        rst_n;
	logic        ioctl_download;
	dl_index_t   ioctl_index;
	ioctl_addr_t ioctl_addr;
	ioctl_word_t ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;
	pif_addr_t   pifrom_wraddress;
	ram_word_t   pifrom_wrdata;
	logic        pifrom_wren;
	ioctl_addr_t ram_wraddr;
	ram_word_t   ram_wrdata;
	logic        ram_wr;
	logic        ram_ready = 1'b0;
	logic        romcopy_start;
	ioctl_addr_t romcopy_size;
	logic        cart_loaded;
	logic        led_user;
	logic        pal;
	logic        fixed_blanks_off;
	logic [1:0]  crop;
	logic [1:0]  ar_mode;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	logic        snac;
	pad_index_t  pad_index;
	logic        snac_data_out;
	logic        snac_data_in;
	user_port_t  user_in;
	user_port_t  user_out;

	// Model state and expected values
	ram_word_t   pif_data_q[$];
	pif_addr_t   pif_addr_q[$];
	ram_word_t   gb_data_q[$];
	ioctl_addr_t gb_addr_q[$];
	logic        pif_level;
	logic        gb_level;
	logic        pif_due;
	logic        gb_due;
	logic        led_exp;
	logic        dl_d;
	logic        rc_exp;
	ram_word_t   pif_exp_data;
	pif_addr_t   pif_exp_addr;
	ram_word_t   gb_exp_data;
	ioctl_addr_t gb_exp_addr;
	ioctl_addr_t last_n64_addr;
	logic        n64_seen = 1'b0;
	logic        ar_check = 1'b0;
	logic [12:0] ar_exp_x;
	logic [12:0] ar_exp_y;
	logic        snac_check = 1'b0;
	logic        snac_idle_check = 1'b0;
	logic [2:0]  snac_exp_pin;
	logic        snac_exp_out;
	logic        snac_exp_in;
	int          ack_delay = 0;
	logic        ack_busy = 1'b0;
	int          pick;
	int          rc_count = 0;
	int          cycle_count = 0;
	int          value_errors = 0;
	int          event_errors = 0;

	n64_glue_top dut_i (.*);

	always #50 clk_1x = ~clk_1x;

	task automatic flag_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		value_errors++;
		$display("ERROR %s expected %h actual %h at cycle %0d", name, expected, actual,
			cycle_count);
	endtask

	task automatic flag_event(input string what);
		event_errors++;
		$display("Check failed at cycle %0d: %s", cycle_count, what);
	endtask

	always @(posedge clk_1x) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles without reaching the end", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ============================================================
	// RAM acknowledge model
	// ============================================================
	always @(posedge clk_1x) begin
		ram_ready <= 1'b0;
		if (ram_wr) begin
			pick = $urandom_range(5, 0);
			if (pick == 0) begin
				ram_ready <= 1'b1;
			end else begin
				ack_delay <= pick;
				ack_busy  <= 1'b1;
			end
		end else if (ack_busy) begin
			if (ack_delay == 1) begin
				ram_ready <= 1'b1;
				ack_busy  <= 1'b0;
			end else begin
				ack_delay <= ack_delay - 1;
			end
		end
	end

	// ============================================================
	// Bus model one cycle behind the host
	// ============================================================
	always @(posedge clk_1x) begin
		if (!rst_n) begin
			pif_level <= 1'b0;
			gb_level  <= 1'b0;
			pif_due   <= 1'b0;
			gb_due    <= 1'b0;
			led_exp   <= 1'b0;
			dl_d      <= 1'b0;
			rc_exp    <= 1'b0;
		end else begin
			pif_level <= ioctl_download && ioctl_index[5:0] == 6'd0;
			gb_level  <= ioctl_download && ioctl_index[5:0] == 6'd2;
			led_exp   <= ioctl_download && (ioctl_index[5:0] == 6'd1 ||
				ioctl_index[5:0] == 6'd2);
			dl_d      <= ioctl_download;
			rc_exp    <= !ioctl_download && dl_d && ioctl_index[5:0] == 6'd1;
			pif_due   <= ioctl_wr && ioctl_addr[1] && pif_level;
			gb_due    <= ioctl_wr && ioctl_addr[1] && gb_level;
			if (romcopy_start)
				rc_count++;
			if (ioctl_wr && ioctl_addr[1] && pif_level) begin
				if (pif_data_q.size() == 0) begin
					flag_event("boot-ROM word completed with nothing queued");
				end else begin
					pif_exp_data <= pif_data_q.pop_front();
					pif_exp_addr <= pif_addr_q.pop_front();
				end
			end
			if (ioctl_wr && ioctl_addr[1] && gb_level) begin
				if (gb_data_q.size() == 0) begin
					flag_event("GB cartridge word completed with nothing queued");
				end else begin
					gb_exp_data <= gb_data_q.pop_front();
					gb_exp_addr <= gb_addr_q.pop_front();
				end
			end
		end
	end

	// ============================================================
	// Assertions
	// ============================================================
	a_pif_wren : assert property (@(posedge clk_1x) disable iff (!rst_n)
		pifrom_wren == pif_due)
		else flag_value("pifrom_wren", 32'(pif_due), 32'(pifrom_wren));
	a_pif_data : assert property (@(posedge clk_1x) disable iff (!rst_n)
		pifrom_wren |-> pifrom_wrdata == pif_exp_data)
		else flag_value("pifrom_wrdata", pif_exp_data, pifrom_wrdata);
	a_pif_addr : assert property (@(posedge clk_1x) disable iff (!rst_n)
		pifrom_wren |-> pifrom_wraddress == pif_exp_addr)
		else flag_value("pifrom_wraddress", 32'(pif_exp_addr), 32'(pifrom_wraddress));
	a_ram_wr : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr == gb_due)
		else flag_value("ram_wr", 32'(gb_due), 32'(ram_wr));
	a_ram_data : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr |-> ram_wrdata == gb_exp_data)
		else flag_value("ram_wrdata", gb_exp_data, ram_wrdata);
	a_ram_addr : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr |-> ram_wraddr == gb_exp_addr)
		else flag_value("ram_wraddr", 32'(gb_exp_addr), 32'(ram_wraddr));
	a_wait_on_req : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr |-> ioctl_wait)
		else flag_event("ioctl_wait low during a RAM write request");
	a_wait_hold : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wait && !ram_ready |=> ioctl_wait)
		else flag_event("ioctl_wait dropped before the RAM acknowledged");
	a_wait_release : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_ready |=> !ioctl_wait)
		else flag_event("ioctl_wait still high one cycle after ram_ready");
	a_host_rule : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wr |-> !ioctl_wait)
		else flag_event("host strobed wr while the bus was in wait");
	a_led : assert property (@(posedge clk_1x) disable iff (!rst_n)
		led_user == led_exp)
		else flag_value("led_user", 32'(led_exp), 32'(led_user));
	a_romcopy : assert property (@(posedge clk_1x) disable iff (!rst_n)
		romcopy_start == rc_exp)
		else flag_value("romcopy_start", 32'(rc_exp), 32'(romcopy_start));
	a_romcopy_size : assert property (@(posedge clk_1x) disable iff (!rst_n)
		romcopy_start |-> romcopy_size == last_n64_addr)
		else flag_value("romcopy_size", 32'(last_n64_addr), 32'(romcopy_size));
	a_cart_sticky : assert property (@(posedge clk_1x) disable iff (!rst_n)
		cart_loaded |=> cart_loaded)
		else flag_event("cart_loaded fell after it was set");
	a_cart_early : assert property (@(posedge clk_1x) disable iff (!rst_n)
		!n64_seen |-> !cart_loaded)
		else flag_event("cart_loaded set before any N64 cartridge download");
	a_arx : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ar_check |-> video_arx == ar_exp_x)
		else flag_value("video_arx", 32'(ar_exp_x), 32'(video_arx));
	a_ary : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ar_check |-> video_ary == ar_exp_y)
		else flag_value("video_ary", 32'(ar_exp_y), 32'(video_ary));
	a_snac_pin : assert property (@(posedge clk_1x) disable iff (!rst_n)
		snac_check |-> user_out[snac_exp_pin] == snac_exp_out)
		else flag_value("user_out pad pin", 32'(snac_exp_out), 32'(user_out[snac_exp_pin]));
	a_snac_in : assert property (@(posedge clk_1x) disable iff (!rst_n)
		snac_check |-> snac_data_in == snac_exp_in)
		else flag_value("snac_data_in", 32'(snac_exp_in), 32'(snac_data_in));
	a_snac_fixed : assert property (@(posedge clk_1x) disable iff (!rst_n)
		snac_check |-> (user_out & 7'h4c) == 7'h4c)
		else flag_value("user_out pins 2 3 6", 32'h4c, 32'(user_out & 7'h4c));
	a_snac_idle : assert property (@(posedge clk_1x) disable iff (!rst_n)
		snac_idle_check |-> user_out == 7'h7f)
		else flag_value("user_out", 32'h7f, 32'(user_out));

	// ============================================================
	// Stimulus
	// ============================================================
	// Call right after a rising edge; back-to-back calls give back-to-back strobes
	task automatic send_halfword(input ioctl_addr_t addr, input ioctl_word_t data);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic send_pif_pair(input ioctl_addr_t base);
		ioctl_word_t hw0;
		ioctl_word_t hw1;
		hw0 = 16'($urandom);
		hw1 = 16'($urandom);
		pif_data_q.push_back({hw0[7:0], hw0[15:8], hw1[7:0], hw1[15:8]});
		pif_addr_q.push_back({ioctl_index[6], base[10:2]});
		send_halfword(base, hw0);
		send_halfword(base | 27'd2, hw1);
		@(posedge clk_1x);
	endtask

	task automatic send_gb_word(input ioctl_addr_t base);
		ioctl_word_t lo;
		ioctl_word_t hi;
		lo = 16'($urandom);
		hi = 16'($urandom);
		gb_data_q.push_back({hi, lo});
		gb_addr_q.push_back(base + 27'd8388608);
		send_halfword(base, lo);
		send_halfword(base | 27'd2, hi);
		@(posedge clk_1x);
		while (ioctl_wait)
			@(posedge clk_1x);
	endtask

	task automatic run_download(input dl_index_t index, input int count);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		if (index[5:0] == 6'd1)
			n64_seen <= 1'b1;
		repeat (2) @(posedge clk_1x);
		for (int i = 0; i < count; i++) begin
			if (index[5:0] == 6'd0)
				send_pif_pair(ioctl_addr_t'(i * 4));
			else if (index[5:0] == 6'd2)
				send_gb_word(ioctl_addr_t'(i * 4));
			else
				send_halfword(ioctl_addr_t'(i * 2), 16'($urandom));
		end
		last_n64_addr  <= ioctl_addr_t'((count - 1) * 2);
		ioctl_download <= 1'b0;
		repeat (4) @(posedge clk_1x);
	endtask

	// Packed as {arx, ary}
	function automatic logic [25:0] expected_ratio(input logic std, input logic [1:0] c,
			input logic fbo, input logic [1:0] mode);
		logic [11:0] x;
		logic [11:0] y;
		if (mode != 2'd0)
			return {11'd0, mode - 2'd1, 13'd0};
		if (fbo) begin
			{x, y} = {12'd4, 12'd3};
		end else begin
			case ({std, c})
				3'b000:  {x, y} = {12'd512, 12'd381};
				3'b001:  {x, y} = {12'd1280, 12'd889};
				3'b010:  {x, y} = {12'd2560, 12'd1714};
				3'b100:  {x, y} = {12'd512, 12'd387};
				3'b101:  {x, y} = {12'd1024, 12'd731};
				default: {x, y} = {12'd2048, 12'd1419};
			endcase
		end
		return {1'b0, x, 1'b0, y};
	endfunction

	task automatic sweep_aspect;
		// Bits 5..0 are standard, fixed blanks, crop and mode
		for (int n = 0; n < 64; n++) begin
			if (n[3:2] == 2'd3)
				continue;
			pal              <= n[5];
			fixed_blanks_off <= n[4];
			crop             <= n[3:2];
			ar_mode          <= n[1:0];
			ar_check         <= 1'b0;
			@(posedge clk_1x);
			{ar_exp_x, ar_exp_y} <= expected_ratio(n[5], n[3:2], n[4], n[1:0]);
			ar_check             <= 1'b1;
			@(posedge clk_1x);
		end
		ar_check <= 1'b0;
	endtask

	function automatic logic [2:0] pin_for_pad(input pad_index_t pad);
		case (pad)
			2'd0:    return 3'd1;
			2'd1:    return 3'd0;
			2'd2:    return 3'd5;
			default: return 3'd4;
		endcase
	endfunction

	task automatic sweep_snac;
		logic       bit_val;
		user_port_t pins;
		logic [2:0] pin;
		snac <= 1'b1;
		for (int n = 0; n < 32; n++) begin
			bit_val = 1'($urandom);
			pins    = 7'($urandom);
			pin     = pin_for_pad(n[4:3]);
			pad_index     <= n[4:3];
			snac_data_out <= bit_val;
			user_in       <= pins;
			snac_check    <= 1'b0;
			@(posedge clk_1x);
			snac_exp_pin <= pin;
			snac_exp_out <= bit_val;
			snac_exp_in  <= pins[pin];
			snac_check   <= 1'b1;
			@(posedge clk_1x);
		end
		snac       <= 1'b0;
		snac_check <= 1'b0;
		@(posedge clk_1x);
		snac_idle_check <= 1'b1;
		repeat (3) @(posedge clk_1x);
		snac_idle_check <= 1'b0;
	endtask

	initial begin
		void'($urandom(50));
		rst_n            = 1'b0;
		ioctl_download   = 1'b0;
		ioctl_index      = 8'd0;
		ioctl_addr       = '0;
		ioctl_dout       = '0;
		ioctl_wr         = 1'b0;
		pal              = 1'b0;
		fixed_blanks_off = 1'b0;
		crop             = 2'd0;
		ar_mode          = 2'd0;
		snac             = 1'b0;
		pad_index        = 2'd0;
		snac_data_out    = 1'b0;
		user_in          = '0;
		repeat (4) @(posedge clk_1x);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_1x);

		run_download(8'd0, 32);
		run_download(8'd64, 32);
		run_download(8'd2, 24);
		run_download(8'd1, 16);
		sweep_aspect();
		sweep_snac();
		repeat (4) @(posedge clk_1x);

		if (pif_data_q.size() != 0 || gb_data_q.size() != 0)
			flag_event("queued words were never written by the DUT");
		if (rc_count != 1)
			flag_value("romcopy_start pulse count", 32'd1, 32'(rc_count));
		if (!cart_loaded)
			flag_value("cart_loaded", 32'd1, 32'(cart_loaded));
		$display("Checks done: %0d value errors, %0d other errors", value_errors,
			event_errors);
		if (value_errors + event_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
